//--- Makefile
SIM := obj_dir/Vriscv_decode_tb

.PHONY: all run clean

all: run

$(SIM): riscv_decode.f $(wildcard hdl/*.sv hdl/*.svh tests/*.sv tests/*.svh)
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module riscv_decode_tb -f riscv_decode.f

run: $(SIM)
	-./$(SIM) > sim.log 2>&1
	@cat sim.log
	@if grep -q "Simulation finished: FAIL" sim.log || \
		! grep -q "Simulation finished: PASS" sim.log; then \
		echo "Run failed, see sim.log"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

//--- hdl/control_table.sv
`include "riscv_decode_settings.svh"

module control_table
(
    input  logic                          clk,
    input  logic                          rst,
    input  riscv_decode_pkg::inst_class_t inst_class,
    input  logic                          funct_legal,
    input  logic                          pc_en_next,
    output logic                          pc_en,
    output logic                          branch,
    output logic                          jump,
    output logic                          mem_read,
    output logic                          mem_to_reg,
    output logic                          mem_write,
    output logic                          alu_src,
    output logic                          reg_write,
    output riscv_decode_pkg::alu_op_t     alu_op,
    output riscv_decode_pkg::rf_sel_t     rf_mux_sel
);

    import riscv_decode_pkg::*;

    logic    branch_d;
    logic    jump_d;
    logic    mem_read_d;
    logic    mem_to_reg_d;
    logic    mem_write_d;
    logic    alu_src_d;
    logic    reg_write_d;
    alu_op_t alu_op_d;
    rf_sel_t rf_mux_sel_d;

    always_comb
    begin
        branch_d     = 1'b0;
        jump_d       = 1'b0;
        mem_read_d   = 1'b0;
        mem_to_reg_d = 1'b0;
        mem_write_d  = 1'b0;
        alu_src_d    = 1'b0;
        reg_write_d  = 1'b0;
        alu_op_d     = `ALU_OP_ADD;
        rf_mux_sel_d = `RF_SEL_ALU;

        if (funct_legal)
        begin
            case (inst_class)
                `CLASS_LUI:
                begin
                    alu_op_d    = `ALU_OP_PASS;  // Immediate straight through
                    alu_src_d   = 1'b1;
                    reg_write_d = 1'b1;
                end
                `CLASS_AUIPC:
                begin
                    alu_op_d     = `ALU_OP_FUNCT;
                    alu_src_d    = 1'b1;
                    reg_write_d  = 1'b1;
                    rf_mux_sel_d = `RF_SEL_PC_IMM;
                end
                `CLASS_JAL:
                begin
                    branch_d     = 1'b1;  // Target from PC + imm
                    jump_d       = 1'b1;
                    alu_src_d    = 1'b1;
                    reg_write_d  = 1'b1;
                    rf_mux_sel_d = `RF_SEL_PC_LINK;
                end
                `CLASS_JALR:
                begin
                    jump_d       = 1'b1;
                    alu_src_d    = 1'b1;
                    reg_write_d  = 1'b1;
                    rf_mux_sel_d = `RF_SEL_PC_LINK;
                end
                `CLASS_BRANCH:
                begin
                    branch_d = 1'b1;
                    alu_op_d = `ALU_OP_BRANCH;
                end
                `CLASS_LOAD:
                begin
                    mem_read_d   = 1'b1;
                    mem_to_reg_d = 1'b1;
                    alu_src_d    = 1'b1;
                    reg_write_d  = 1'b1;
                end
                `CLASS_STORE:
                begin
                    mem_write_d = 1'b1;
                    alu_src_d   = 1'b1;
                end
                `CLASS_ARITH_I:
                begin
                    alu_src_d   = 1'b1;
                    reg_write_d = 1'b1;
                end
                `CLASS_ARITH_R:
                begin
                    alu_op_d    = `ALU_OP_FUNCT;
                    reg_write_d = 1'b1;
                end
                default:
                    alu_op_d = `ALU_OP_ADD;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pc_en      <= 1'b0;
            branch     <= 1'b0;
            jump       <= 1'b0;
            mem_read   <= 1'b0;
            mem_to_reg <= 1'b0;
            mem_write  <= 1'b0;
            alu_src    <= 1'b0;
            reg_write  <= 1'b0;
            alu_op     <= `ALU_OP_ADD;
            rf_mux_sel <= `RF_SEL_ALU;
        end
        else
        begin
            pc_en      <= pc_en_next;  // Not masked by funct_legal
            branch     <= branch_d;
            jump       <= jump_d;
            mem_read   <= mem_read_d;
            mem_to_reg <= mem_to_reg_d;
            mem_write  <= mem_write_d;
            alu_src    <= alu_src_d;
            reg_write  <= reg_write_d;
            alu_op     <= alu_op_d;
            rf_mux_sel <= rf_mux_sel_d;
        end
    end

endmodule

//--- hdl/inst_classifier.sv
`include "riscv_decode_settings.svh"

module inst_classifier
(
    input  riscv_decode_pkg::inst_t       inst,
    output riscv_decode_pkg::inst_class_t inst_class,
    output logic                          funct_legal,
    output logic                          pc_en_next
);

    import riscv_decode_pkg::*;

    opcode_t opcode;
    funct3_t funct3;
    funct7_t funct7;
    logic    f7_known;

    assign opcode = inst[6:2];  // inst[1:0] ignored
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign f7_known = (funct7 == `F7_BASE) || (funct7 == `F7_ALT);

    always_comb
    begin
        case (opcode)
            `OPCODE_LUI:     inst_class = `CLASS_LUI;
            `OPCODE_AUIPC:   inst_class = `CLASS_AUIPC;
            `OPCODE_JAL:     inst_class = `CLASS_JAL;
            `OPCODE_JALR:    inst_class = `CLASS_JALR;
            `OPCODE_BRANCH:  inst_class = `CLASS_BRANCH;
            `OPCODE_LOAD:    inst_class = `CLASS_LOAD;
            `OPCODE_STORE:   inst_class = `CLASS_STORE;
            `OPCODE_ARITH_I: inst_class = `CLASS_ARITH_I;
            `OPCODE_ARITH_R: inst_class = `CLASS_ARITH_R;
            `OPCODE_FENCE,
            `OPCODE_SYSTEM:  inst_class = `CLASS_NONE;  // Decoded as no-op
            default:         inst_class = `CLASS_NONE;
        endcase
    end

    // PC keeps running for any known class, legal funct or not
    assign pc_en_next = (inst_class != `CLASS_NONE);

    always_comb
    begin
        case (inst_class)
            `CLASS_LUI,
            `CLASS_AUIPC,
            `CLASS_JAL,
            `CLASS_JALR:
                funct_legal = 1'b1;
            `CLASS_BRANCH:
                case (funct3)
                    `BR_BEQ, `BR_BNE, `BR_BLT,
                    `BR_BGE, `BR_BLTU, `BR_BGEU:
                        funct_legal = 1'b1;
                    default:
                        funct_legal = 1'b0;
                endcase
            `CLASS_LOAD:
                case (funct3)
                    `F3_LB, `F3_LH, `F3_LW, `F3_LBU, `F3_LHU:
                        funct_legal = 1'b1;
                    default:
                        funct_legal = 1'b0;
                endcase
            `CLASS_STORE:
                case (funct3)
                    `F3_SB, `F3_SH, `F3_SW:
                        funct_legal = 1'b1;
                    default:
                        funct_legal = 1'b0;
                endcase
            `CLASS_ARITH_I:
                funct_legal = (funct3 != `F3_SRLI_SRAI) || f7_known;  // Shift right only
            `CLASS_ARITH_R:
                funct_legal = ((funct3 != `F3_ADD_SUB) && (funct3 != `F3_SRL_SRA))
                              || f7_known;
            default:
                funct_legal = 1'b0;
        endcase
    end

endmodule

//--- hdl/operand_attr.sv
`include "riscv_decode_settings.svh"

module operand_attr
(
    input  logic                           clk,
    input  logic                           rst,
    input  riscv_decode_pkg::inst_class_t  inst_class,
    input  logic                           funct_legal,
    input  riscv_decode_pkg::funct3_t      funct3,
    output logic                           signed_inst,
    output riscv_decode_pkg::access_size_t au_inst_sel
);

    import riscv_decode_pkg::*;

    logic         signed_d;
    access_size_t size_d;
    access_size_t f3_size;

    // Loads and stores share the size encoding in funct3[1:0]
    always_comb
    begin
        case (funct3)
            `F3_LB, `F3_LBU: f3_size = `SIZE_BYTE;
            `F3_LH, `F3_LHU: f3_size = `SIZE_HALF;
            default:         f3_size = `SIZE_WORD;
        endcase
    end

    always_comb
    begin
        signed_d = 1'b0;
        size_d   = `SIZE_WORD;

        if (funct_legal)
        begin
            signed_d = 1'b1;
            case (inst_class)
                `CLASS_BRANCH:
                    if ((funct3 == `BR_BLTU) || (funct3 == `BR_BGEU))
                        signed_d = 1'b0;
                `CLASS_LOAD:
                begin
                    if ((funct3 == `F3_LBU) || (funct3 == `F3_LHU))
                        signed_d = 1'b0;  // Zero extend
                    size_d = f3_size;
                end
                `CLASS_STORE:
                    size_d = f3_size;
                `CLASS_ARITH_R:
                    if (funct3 == `F3_SLTU)
                        signed_d = 1'b0;
                default:
                    size_d = `SIZE_WORD;  // SLTIU stays signed
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            signed_inst <= 1'b0;
            au_inst_sel <= `SIZE_WORD;
        end
        else
        begin
            signed_inst <= signed_d;
            au_inst_sel <= size_d;
        end
    end

endmodule

//--- hdl/riscv_decode.sv
module riscv_decode
(
    input  logic                           clk,
    input  logic                           rst,
    input  riscv_decode_pkg::inst_t        inst,
    output logic                           pc_en,
    output logic                           branch,
    output logic                           jump,
    output logic                           mem_read,
    output logic                           mem_to_reg,
    output logic                           mem_write,
    output logic                           alu_src,
    output logic                           reg_write,
    output riscv_decode_pkg::alu_op_t      alu_op,
    output riscv_decode_pkg::rf_sel_t      rf_mux_sel,
    output logic                           signed_inst,
    output riscv_decode_pkg::access_size_t au_inst_sel
);

    import riscv_decode_pkg::*;

    inst_class_t inst_class;
    logic        funct_legal;
    logic        pc_en_next;

    inst_classifier i_inst_classifier
    (
        .inst        (inst),
        .inst_class  (inst_class),
        .funct_legal (funct_legal),
        .pc_en_next  (pc_en_next)
    );

    control_table i_control_table
    (
        .clk         (clk),
        .rst         (rst),
        .inst_class  (inst_class),
        .funct_legal (funct_legal),
        .pc_en_next  (pc_en_next),
        .pc_en       (pc_en),
        .branch      (branch),
        .jump        (jump),
        .mem_read    (mem_read),
        .mem_to_reg  (mem_to_reg),
        .mem_write   (mem_write),
        .alu_src     (alu_src),
        .reg_write   (reg_write),
        .alu_op      (alu_op),
        .rf_mux_sel  (rf_mux_sel)
    );

    operand_attr i_operand_attr
    (
        .clk         (clk),
        .rst         (rst),
        .inst_class  (inst_class),
        .funct_legal (funct_legal),
        .funct3      (inst[14:12]),  // funct3 field
        .signed_inst (signed_inst),
        .au_inst_sel (au_inst_sel)
    );

endmodule

//--- hdl/riscv_decode_pkg.sv
package riscv_decode_pkg;

    // Raw instruction word
    typedef logic [31:0] inst_t;

    // Fields sliced from the instruction
    typedef logic [4:0] opcode_t;   // inst[6:2]
    typedef logic [2:0] funct3_t;   // inst[14:12]
    typedef logic [6:0] funct7_t;   // inst[31:25]

    // Decoded class code
    typedef logic [3:0] inst_class_t;

    // Control field encodings
    typedef logic [1:0] alu_op_t;
    typedef logic [1:0] rf_sel_t;
    typedef logic [1:0] access_size_t;

endpackage

//--- hdl/riscv_decode_settings.svh
`ifndef RISCV_DECODE_SETTINGS_SVH
`define RISCV_DECODE_SETTINGS_SVH

// Major opcodes, inst[6:2]
`define OPCODE_LUI      5'b01101
`define OPCODE_AUIPC    5'b00101
`define OPCODE_JAL      5'b11011
`define OPCODE_JALR     5'b11001
`define OPCODE_BRANCH   5'b11000
`define OPCODE_LOAD     5'b00000
`define OPCODE_STORE    5'b01000
`define OPCODE_ARITH_I  5'b00100
`define OPCODE_ARITH_R  5'b01100
`define OPCODE_FENCE    5'b00011
`define OPCODE_SYSTEM   5'b11100

`define BR_BEQ          3'b000
`define BR_BNE          3'b001
`define BR_BLT          3'b100
`define BR_BGE          3'b101
`define BR_BLTU         3'b110
`define BR_BGEU         3'b111

`define F3_LB           3'b000
`define F3_LH           3'b001
`define F3_LW           3'b010
`define F3_LBU          3'b100
`define F3_LHU          3'b101

`define F3_SB           3'b000
`define F3_SH           3'b001
`define F3_SW           3'b010

`define F3_SLTIU        3'b011
`define F3_SRLI_SRAI    3'b101

`define F3_ADD_SUB      3'b000
`define F3_SLTU         3'b011
`define F3_SRL_SRA      3'b101

`define F7_BASE         7'b0000000
`define F7_ALT          7'b0100000  // SUB, SRA, SRAI

// Decoded class codes
`define CLASS_NONE      4'd0
`define CLASS_LUI       4'd1
`define CLASS_AUIPC     4'd2
`define CLASS_JAL       4'd3
`define CLASS_JALR      4'd4
`define CLASS_BRANCH    4'd5
`define CLASS_LOAD      4'd6
`define CLASS_STORE     4'd7
`define CLASS_ARITH_I   4'd8
`define CLASS_ARITH_R   4'd9

`define ALU_OP_ADD      2'b00
`define ALU_OP_BRANCH   2'b01
`define ALU_OP_FUNCT    2'b10
`define ALU_OP_PASS     2'b11

`define RF_SEL_ALU      2'b00
`define RF_SEL_PC_IMM   2'b01
`define RF_SEL_PC_LINK  2'b10

`define SIZE_WORD       2'b00
`define SIZE_HALF       2'b01
`define SIZE_BYTE       2'b10

`endif

//--- riscv_decode.f
+incdir+hdl
+incdir+tests
hdl/riscv_decode_pkg.sv
hdl/inst_classifier.sv
hdl/control_table.sv
hdl/operand_attr.sv
hdl/riscv_decode.sv
tests/riscv_decode_chk.sv
tests/riscv_decode_tb.sv

//--- tests/riscv_decode_chk.sv
module riscv_decode_chk
(
    input logic                      clk,
    input logic                      rst,
    input logic                      pc_en,
    input logic                      branch,
    input logic                      jump,
    input logic                      mem_read,
    input logic                      mem_to_reg,
    input logic                      mem_write,
    input logic                      alu_src,
    input logic                      reg_write,
    input riscv_decode_pkg::alu_op_t alu_op,
    input riscv_decode_pkg::rf_sel_t rf_mux_sel
);

    timeunit 1ns;
    timeprecision 100ps;

    logic any_control;

    assign any_control = branch || jump || mem_read || mem_to_reg || mem_write || alu_src
                         || reg_write || (alu_op != 2'b00) || (rf_mux_sel != 2'b00);

    mem_exclusive: assert property (@(posedge clk) disable iff (rst) !(mem_read && mem_write))
        else $error("mem_read and mem_write high together");

    load_writes_back: assert property (@(posedge clk) disable iff (rst) mem_to_reg |-> reg_write)
        else $error("mem_to_reg without reg_write");

    jump_links: assert property (@(posedge clk) disable iff (rst) jump |-> reg_write)
        else $error("jump without reg_write");

    control_needs_pc: assert property (@(posedge clk) disable iff (rst) any_control |-> pc_en)
        else $error("Control active while pc_en is low");

endmodule

//--- tests/riscv_decode_model.svh
`include "riscv_decode_settings.svh"

// Expected outputs packed MSB first: pc_en, branch, jump, mem_read, mem_to_reg,
// mem_write, alu_src, reg_write, alu_op, rf_mux_sel, signed_inst, au_inst_sel
function automatic logic [14:0] expected_controls(input inst_t word);
    opcode_t      opc;
    funct3_t      f3;
    logic         f7_ok;
    logic         known;
    logic         legal;
    logic [6:0]   flags;  // branch jump mem_read mem_to_reg mem_write alu_src reg_write
    alu_op_t      aop;
    rf_sel_t      rfs;
    logic         sgn;
    access_size_t size;
    opc   = word[6:2];
    f3    = word[14:12];
    f7_ok = (word[31:25] == `F7_BASE) || (word[31:25] == `F7_ALT);
    known = 1'b1;
    flags = 7'b0;
    aop   = `ALU_OP_ADD;
    rfs   = `RF_SEL_ALU;
    case (opc)
        `OPCODE_LUI:     flags = 7'b0000011;
        `OPCODE_AUIPC:   flags = 7'b0000011;
        `OPCODE_JAL:     flags = 7'b1100011;
        `OPCODE_JALR:    flags = 7'b0100011;
        `OPCODE_BRANCH:  flags = 7'b1000000;
        `OPCODE_LOAD:    flags = 7'b0011011;
        `OPCODE_STORE:   flags = 7'b0000110;
        `OPCODE_ARITH_I: flags = 7'b0000011;
        `OPCODE_ARITH_R: flags = 7'b0000001;
        default:         known = 1'b0;  // FENCE, SYSTEM, unknown
    endcase
    case (opc)
        `OPCODE_BRANCH:  legal = (f3 != 3'd2) && (f3 != 3'd3);
        `OPCODE_LOAD:    legal = (f3 <= 3'd2) || (f3 == 3'd4) || (f3 == 3'd5);
        `OPCODE_STORE:   legal = (f3 <= 3'd2);
        `OPCODE_ARITH_I: legal = (f3 != 3'd5) || f7_ok;
        `OPCODE_ARITH_R: legal = !((f3 == 3'd0) || (f3 == 3'd5)) || f7_ok;
        default:         legal = known;
    endcase
    if (opc == `OPCODE_LUI)
        aop = `ALU_OP_PASS;
    else if ((opc == `OPCODE_AUIPC) || (opc == `OPCODE_ARITH_R))
        aop = `ALU_OP_FUNCT;
    else if (opc == `OPCODE_BRANCH)
        aop = `ALU_OP_BRANCH;
    if (opc == `OPCODE_AUIPC)
        rfs = `RF_SEL_PC_IMM;
    else if ((opc == `OPCODE_JAL) || (opc == `OPCODE_JALR))
        rfs = `RF_SEL_PC_LINK;
    sgn = 1'b1;
    if (((opc == `OPCODE_BRANCH) && (f3 >= 3'd6)) ||
        ((opc == `OPCODE_LOAD) && (f3 >= 3'd4)) ||
        ((opc == `OPCODE_ARITH_R) && (f3 == 3'd3)))
        sgn = 1'b0;  // Unsigned compare or zero extend
    size = `SIZE_WORD;
    if ((opc == `OPCODE_LOAD) || (opc == `OPCODE_STORE))
        size = (f3[1:0] == 2'b00) ? `SIZE_BYTE : (f3[1:0] == 2'b01) ? `SIZE_HALF : `SIZE_WORD;
    if (!(known && legal))
        return {known, 14'b0};
    return {1'b1, flags, aop, rfs, sgn, size};
endfunction

//--- tests/riscv_decode_tb.sv
`include "riscv_decode_settings.svh"

module riscv_decode_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import riscv_decode_pkg::*;

    localparam int RANDOM_CYCLES = 5000;
    localparam int NUM_DIRECTED  = 21;
    localparam int POLL_LIMIT    = 20;

    logic         clk;
    logic         rst;
    inst_t        inst;
    logic         pc_en;
    logic         branch;
    logic         jump;
    logic         mem_read;
    logic         mem_to_reg;
    logic         mem_write;
    logic         alu_src;
    logic         reg_write;
    alu_op_t      alu_op;
    rf_sel_t      rf_mux_sel;
    logic         signed_inst;
    access_size_t au_inst_sel;

    int    rise_count = 0;
    logic  verdict_printed;
    inst_t sent_inst;  // Instruction whose outputs are due next edge
    logic  sent_rst;

    opcode_t known_ops [11] = '{`OPCODE_LUI, `OPCODE_AUIPC, `OPCODE_JAL, `OPCODE_JALR,
                                `OPCODE_BRANCH, `OPCODE_LOAD, `OPCODE_STORE, `OPCODE_ARITH_I,
                                `OPCODE_ARITH_R, `OPCODE_FENCE, `OPCODE_SYSTEM};

    // Legal rows, illegal funct, slt/sltu, FENCE, SYSTEM, unknown
    inst_t directed [NUM_DIRECTED] = '{
        32'h12345037, 32'h00001017, 32'h0000006f, 32'h00000067, 32'h00000063,
        32'h00006063, 32'h00002063, 32'h00000003, 32'h00005003, 32'h00003003,
        32'h00002023, 32'h00004023, 32'h00003013, 32'h40005013, 32'h02005013,
        32'h00003033, 32'h40000033, 32'h02000033, 32'h0000000f, 32'h00000073,
        32'h0000007f};

    `include "riscv_decode_model.svh"

    riscv_decode i_riscv_decode (.*);

    bind riscv_decode riscv_decode_chk i_riscv_decode_chk (.*);

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #5 clk = 1'b1;
            rise_count++;
            #5 clk = 1'b0;
        end
    end

    task automatic fail_run(input string why);
        verdict_printed = 1'b1;
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    // Returns half a nanosecond after the next rising edge
    task automatic wait_rise();
        int start;
        int polls;
        start = rise_count;
        polls = 0;
        #0.5;
        while ((rise_count == start) && (polls < POLL_LIMIT))
        begin
            #1;
            polls++;
        end
        if (rise_count == start)
            fail_run("Timed out waiting for a rising clock edge");
    endtask

    task automatic present(input inst_t word, input logic reset_level);
        #0.5;
        inst      = word;
        rst       = reset_level;
        sent_inst = word;
        sent_rst  = reset_level;
    endtask

    task automatic check_signal(input string name, input logic [1:0] got,
                                input logic [1:0] exp);
        assert (got === exp)
        else
            fail_run($sformatf("[FAIL] %s = 0x%0h, expected 0x%0h (inst 0x%08h)",
                               name, got, exp, sent_inst));
    endtask

    task automatic check_outputs();
        logic [14:0] exp;
        exp = sent_rst ? 15'd0 : expected_controls(sent_inst);
        check_signal("pc_en", {1'b0, pc_en}, {1'b0, exp[14]});
        check_signal("branch", {1'b0, branch}, {1'b0, exp[13]});
        check_signal("jump", {1'b0, jump}, {1'b0, exp[12]});
        check_signal("mem_read", {1'b0, mem_read}, {1'b0, exp[11]});
        check_signal("mem_to_reg", {1'b0, mem_to_reg}, {1'b0, exp[10]});
        check_signal("mem_write", {1'b0, mem_write}, {1'b0, exp[9]});
        check_signal("alu_src", {1'b0, alu_src}, {1'b0, exp[8]});
        check_signal("reg_write", {1'b0, reg_write}, {1'b0, exp[7]});
        check_signal("alu_op", alu_op, exp[6:5]);
        check_signal("rf_mux_sel", rf_mux_sel, exp[4:3]);
        check_signal("signed_inst", {1'b0, signed_inst}, {1'b0, exp[2]});
        check_signal("au_inst_sel", au_inst_sel, exp[1:0]);
    endtask

    function automatic inst_t random_inst();
        inst_t    word;
        logic [3:0] idx;
        word = $urandom;
        if ($urandom_range(99) < 80)
        begin
            idx       = 4'($urandom_range(10));
            word[6:2] = known_ops[idx];
        end
        if ($urandom_range(1) == 1)
            word[31:25] = ($urandom_range(1) == 1) ? `F7_ALT : `F7_BASE;
        return word;
    endfunction

    initial
    begin
        rst             = 1'b1;
        inst            = 32'h0000_006f;  // JAL, nonzero controls unless held in reset
        sent_inst       = 32'h0000_006f;
        sent_rst        = 1'b1;
        verdict_printed = 1'b0;
        void'($urandom(32'h220782d7));

        // JAL while in reset, unknown opcode on release
        for (int i = 0; i < 5; i++)
        begin
            wait_rise();
            check_outputs();
            present((i < 4) ? 32'h0000_006f : 32'hffff_ffff, (i < 4));
        end
        for (int i = 0; i < NUM_DIRECTED; i++)
        begin
            wait_rise();
            check_outputs();
            present(directed[i], 1'b0);
        end
        for (int i = 0; i < RANDOM_CYCLES; i++)
        begin
            wait_rise();
            check_outputs();
            present(random_inst(), 1'b0);
        end
        wait_rise();
        check_outputs();  // Last instruction in flight

        verdict_printed = 1'b1;
        $display("Simulation finished: PASS");
        $finish;
    end

    final
    begin
        if (!verdict_printed)
            $display("Simulation finished: FAIL");  // Stopped by a bound assertion
    end

endmodule
